// File: verilog/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Byte address width on the core side and on the bus
`define LSU_ADDR_WIDTH 32

// Bus word width, strobe width is this divided by 8
`define LSU_DATA_WIDTH 32

// Data memory depth in words, indexed by address bits 11:2
`define LSU_MEM_WORDS 1024

`endif

// File: verilog/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // RISC-V funct3 codes for loads and stores
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_BU = 3'b100,
        LS_HU = 3'b101
    } ls_width_e;

    typedef enum logic {
        LS_LOAD  = 1'b0,
        LS_STORE = 1'b1
    } ls_kind_e;

endpackage

`default_nettype wire

// File: verilog/lsu_decode.sv
`default_nettype none
`include "lsu_defines.svh"

module lsu_decode (
    input  wire                           CLK,
    input  wire                           rstn,
    input  wire                           req,
    input  wire lsu_pkg::ls_kind_e        req_kind,
    input  wire lsu_pkg::ls_width_e       req_width,
    input  wire [`LSU_ADDR_WIDTH-1:0]     req_addr,
    input  wire [`LSU_DATA_WIDTH-1:0]     req_wdata,
    input  wire                           busy,
    output logic                          dec_valid,
    output logic                          dec_misaligned,
    output lsu_pkg::ls_kind_e             dec_kind,
    output lsu_pkg::ls_width_e            dec_width,
    output logic [`LSU_ADDR_WIDTH-1:0]    dec_word_addr,
    output logic [`LSU_DATA_WIDTH/8-1:0]  dec_strb,
    output logic [`LSU_DATA_WIDTH-1:0]    dec_wdata,
    output logic [1:0]                    dec_offset
);
    import lsu_pkg::*;

    localparam int STRB_W = `LSU_DATA_WIDTH / 8;
    localparam logic [STRB_W-1:0] BYTE_MASK = 1;
    localparam logic [STRB_W-1:0] HALF_MASK = 3;

    logic                       accept;
    logic                       bad_align;
    logic [STRB_W-1:0]          strb;
    logic [`LSU_DATA_WIDTH-1:0] lane_data;

    // Requests arriving while busy are dropped
    assign accept = req && !busy;

    always_comb begin
        bad_align = 1'b0;
        strb      = '1;
        lane_data = req_wdata;
        case (req_width)
            LS_B, LS_BU: begin
                strb      = BYTE_MASK << req_addr[1:0];
                lane_data = {STRB_W{req_wdata[7:0]}};
            end
            LS_H, LS_HU: begin
                bad_align = req_addr[0];
                strb      = HALF_MASK << req_addr[1:0];
                lane_data = {(STRB_W / 2){req_wdata[15:0]}};
            end
            default: begin
                bad_align = (req_addr[1:0] != 2'b00);
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rstn) begin
            dec_valid      <= 1'b0;
            dec_misaligned <= 1'b0;
        end else begin
            dec_valid      <= accept && !bad_align;
            dec_misaligned <= accept && bad_align;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            dec_kind      <= req_kind;
            dec_width     <= req_width;
            dec_word_addr <= {req_addr[`LSU_ADDR_WIDTH-1:2], 2'b00};
            dec_strb      <= strb;
            dec_wdata     <= lane_data;
            dec_offset    <= req_addr[1:0];
        end
    end

    // An issued request always finds busy already set
    a_issue_sets_busy: assert property (@(posedge CLK) disable iff (rstn)
        (dec_valid || dec_misaligned) |-> busy);

endmodule

`default_nettype wire

// File: verilog/lsu_bus_execute.sv
`default_nettype none
`include "lsu_defines.svh"

module lsu_bus_execute (
    input  wire                           CLK,
    input  wire                           rstn,
    input  wire                           dec_valid,
    input  wire lsu_pkg::ls_kind_e        dec_kind,
    input  wire [`LSU_ADDR_WIDTH-1:0]     dec_word_addr,
    input  wire [`LSU_DATA_WIDTH/8-1:0]   dec_strb,
    input  wire [`LSU_DATA_WIDTH-1:0]     dec_wdata,
    input  wire [1:0]                     dec_offset,
    input  wire lsu_pkg::ls_width_e       dec_width,
    output logic [`LSU_ADDR_WIDTH-1:0]    LSU_AXI4_ARADDR,
    output logic                          LSU_AXI4_ARVALID,
    input  wire                           LSU_AXI4_ARREADY,
    input  wire [`LSU_DATA_WIDTH-1:0]     LSU_AXI4_RDATA,
    input  wire                           LSU_AXI4_RVALID,
    output logic                          LSU_AXI4_RREADY,
    output logic [`LSU_ADDR_WIDTH-1:0]    LSU_AXI4_AWADDR,
    output logic                          LSU_AXI4_AWVALID,
    input  wire                           LSU_AXI4_AWREADY,
    output logic [`LSU_DATA_WIDTH-1:0]    LSU_AXI4_WDATA,
    output logic [`LSU_DATA_WIDTH/8-1:0]  LSU_AXI4_WSTRB,
    output logic                          LSU_AXI4_WVALID,
    input  wire                           LSU_AXI4_WREADY,
    input  wire                           LSU_AXI4_BVALID,
    output logic                          LSU_AXI4_BREADY,
    output logic                          rsp_valid,
    output lsu_pkg::ls_kind_e             rsp_kind,
    output logic [`LSU_DATA_WIDTH-1:0]    rsp_word,
    output logic [1:0]                    rsp_offset,
    output lsu_pkg::ls_width_e            rsp_width
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE,
        ST_RESP
    } state_e;

    state_e                     state;
    logic [`LSU_ADDR_WIDTH-1:0] addr_q;
    logic                       start;

    assign start = (state == ST_IDLE) && dec_valid;

    // One address register serves both channels
    assign LSU_AXI4_ARADDR = addr_q;
    assign LSU_AXI4_AWADDR = addr_q;
    assign LSU_AXI4_RREADY = (state == ST_READ);
    assign LSU_AXI4_BREADY = (state == ST_WRITE);
    assign rsp_valid       = (state == ST_RESP);

    always_ff @(posedge CLK) begin
        if (rstn) begin
            state            <= ST_IDLE;
            LSU_AXI4_ARVALID <= 1'b0;
            LSU_AXI4_AWVALID <= 1'b0;
            LSU_AXI4_WVALID  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start && dec_kind == LS_LOAD) begin
                        LSU_AXI4_ARVALID <= 1'b1;
                        state            <= ST_READ;
                    end else if (start) begin
                        LSU_AXI4_AWVALID <= 1'b1;
                        LSU_AXI4_WVALID  <= 1'b1;
                        state            <= ST_WRITE;
                    end
                end
                ST_READ: begin
                    if (LSU_AXI4_ARVALID && LSU_AXI4_ARREADY) begin
                        LSU_AXI4_ARVALID <= 1'b0;
                    end
                    if (LSU_AXI4_RVALID) begin
                        state <= ST_RESP;
                    end
                end
                ST_WRITE: begin
                    // AW and W drop independently as each one transfers
                    if (LSU_AXI4_AWVALID && LSU_AXI4_AWREADY) begin
                        LSU_AXI4_AWVALID <= 1'b0;
                    end
                    if (LSU_AXI4_WVALID && LSU_AXI4_WREADY) begin
                        LSU_AXI4_WVALID <= 1'b0;
                    end
                    if (LSU_AXI4_BVALID) begin
                        state <= ST_RESP;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            addr_q         <= dec_word_addr;
            LSU_AXI4_WDATA <= dec_wdata;
            LSU_AXI4_WSTRB <= dec_strb;
            rsp_kind       <= dec_kind;
            rsp_offset     <= dec_offset;
            rsp_width      <= dec_width;
        end
        if (LSU_AXI4_RVALID && LSU_AXI4_RREADY) begin
            rsp_word <= LSU_AXI4_RDATA;
        end
    end

    a_ar_hold: assert property (@(posedge CLK) disable iff (rstn)
        LSU_AXI4_ARVALID && !LSU_AXI4_ARREADY |=>
            LSU_AXI4_ARVALID && $stable(LSU_AXI4_ARADDR));

    a_aw_hold: assert property (@(posedge CLK) disable iff (rstn)
        LSU_AXI4_AWVALID && !LSU_AXI4_AWREADY |=>
            LSU_AXI4_AWVALID && $stable(LSU_AXI4_AWADDR));

    a_w_hold: assert property (@(posedge CLK) disable iff (rstn)
        LSU_AXI4_WVALID && !LSU_AXI4_WREADY |=>
            LSU_AXI4_WVALID && $stable(LSU_AXI4_WDATA) && $stable(LSU_AXI4_WSTRB));

endmodule

`default_nettype wire

// File: verilog/lsu_load_result.sv
`default_nettype none
`include "lsu_defines.svh"

module lsu_load_result (
    input  wire                         CLK,
    input  wire                         rstn,
    input  wire                         req,
    input  wire                         rsp_valid,
    input  wire lsu_pkg::ls_kind_e      rsp_kind,
    input  wire [`LSU_DATA_WIDTH-1:0]   rsp_word,
    input  wire [1:0]                   rsp_offset,
    input  wire lsu_pkg::ls_width_e     rsp_width,
    input  wire                         dec_misaligned,
    output logic                        done,
    output logic [`LSU_DATA_WIDTH-1:0]  load_data,
    output logic                        misaligned,
    output logic                        busy
);
    import lsu_pkg::*;

    localparam int DW = `LSU_DATA_WIDTH;

    logic [7:0]    sel_byte;
    logic [15:0]   sel_half;
    logic [DW-1:0] extended;
    logic          finish;

    assign finish   = rsp_valid || dec_misaligned;
    assign sel_byte = rsp_word[{rsp_offset, 3'b000} +: 8];
    assign sel_half = rsp_word[{rsp_offset[1], 4'b0000} +: 16];

    always_comb begin
        case (rsp_width)
            LS_B:    extended = {{(DW - 8){sel_byte[7]}}, sel_byte};
            LS_BU:   extended = {{(DW - 8){1'b0}}, sel_byte};
            LS_H:    extended = {{(DW - 16){sel_half[15]}}, sel_half};
            LS_HU:   extended = {{(DW - 16){1'b0}}, sel_half};
            default: extended = rsp_word;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rstn) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            misaligned <= 1'b0;
        end else begin
            done       <= finish;
            misaligned <= dec_misaligned;
            // Same acceptance rule as decode
            if (req && !busy) begin
                busy <= 1'b1;
            end else if (finish) begin
                busy <= 1'b0;
            end
        end
    end

    // Stores and misaligned requests report zero
    always_ff @(posedge CLK) begin
        if (finish) begin
            load_data <= (rsp_valid && rsp_kind == LS_LOAD) ? extended : '0;
        end
    end

    a_done_pulse: assert property (@(posedge CLK) disable iff (rstn)
        done |=> !done);

endmodule

`default_nettype wire

// File: verilog/sram_data.sv
`default_nettype none
`include "lsu_defines.svh"

module sram_data (
    input  wire                          CLK,
    input  wire                          rstn,
    input  wire [`LSU_ADDR_WIDTH-1:0]    LSU_AXI4_ARADDR,
    input  wire                          LSU_AXI4_ARVALID,
    output logic                         LSU_AXI4_ARREADY,
    output logic [`LSU_DATA_WIDTH-1:0]   LSU_AXI4_RDATA,
    output logic                         LSU_AXI4_RVALID,
    input  wire                          LSU_AXI4_RREADY,
    input  wire [`LSU_ADDR_WIDTH-1:0]    LSU_AXI4_AWADDR,
    input  wire                          LSU_AXI4_AWVALID,
    output logic                         LSU_AXI4_AWREADY,
    input  wire [`LSU_DATA_WIDTH-1:0]    LSU_AXI4_WDATA,
    input  wire [`LSU_DATA_WIDTH/8-1:0]  LSU_AXI4_WSTRB,
    input  wire                          LSU_AXI4_WVALID,
    output logic                         LSU_AXI4_WREADY,
    output logic                         LSU_AXI4_BVALID,
    input  wire                          LSU_AXI4_BREADY
);
    localparam int IDX_W  = $clog2(`LSU_MEM_WORDS);
    localparam int STRB_W = `LSU_DATA_WIDTH / 8;

    typedef enum logic [1:0] {
        R_IDLE,
        R_DATA,
        R_WAIT
    } rstate_e;

    typedef enum logic [1:0] {
        W_IDLE,
        W_WAIT_W,
        W_WAIT_AW,
        W_WRITE
    } wstate_e;

    rstate_e                    state_read;
    wstate_e                    state_write;
    logic                       ar_fire;
    logic                       aw_fire;
    logic                       w_fire;
    logic                       mem_we;
    logic [IDX_W-1:0]           read_idx;
    logic [IDX_W-1:0]           write_idx;
    logic [`LSU_DATA_WIDTH-1:0] write_data;
    logic [STRB_W-1:0]          write_strb;
    logic [`LSU_DATA_WIDTH-1:0] mem [0:`LSU_MEM_WORDS-1];

    assign ar_fire = LSU_AXI4_ARVALID && LSU_AXI4_ARREADY;
    assign aw_fire = LSU_AXI4_AWVALID && LSU_AXI4_AWREADY;
    assign w_fire  = LSU_AXI4_WVALID && LSU_AXI4_WREADY;
    // Only the first cycle of W_WRITE touches the array
    assign mem_we  = (state_write == W_WRITE) && !LSU_AXI4_BVALID;

    always_ff @(posedge CLK) begin
        if (rstn) begin
            state_read       <= R_IDLE;
            LSU_AXI4_ARREADY <= 1'b0;
            LSU_AXI4_RVALID  <= 1'b0;
        end else begin
            case (state_read)
                R_IDLE: begin
                    LSU_AXI4_ARREADY <= 1'b1;
                    if (ar_fire) begin
                        LSU_AXI4_ARREADY <= 1'b0;
                        state_read       <= R_DATA;
                    end
                end
                R_DATA: begin
                    LSU_AXI4_RVALID <= 1'b1;
                    state_read      <= R_WAIT;
                end
                R_WAIT: begin
                    if (LSU_AXI4_RREADY) begin
                        LSU_AXI4_RVALID <= 1'b0;
                        state_read      <= R_IDLE;
                    end
                end
                default: begin
                    state_read <= R_IDLE;
                end
            endcase
        end
    end

    // AW and W may arrive together or in either order
    always_ff @(posedge CLK) begin
        if (rstn) begin
            state_write      <= W_IDLE;
            LSU_AXI4_AWREADY <= 1'b0;
            LSU_AXI4_WREADY  <= 1'b0;
            LSU_AXI4_BVALID  <= 1'b0;
        end else begin
            case (state_write)
                W_IDLE: begin
                    LSU_AXI4_AWREADY <= 1'b1;
                    LSU_AXI4_WREADY  <= 1'b1;
                    if (aw_fire && w_fire) begin
                        LSU_AXI4_AWREADY <= 1'b0;
                        LSU_AXI4_WREADY  <= 1'b0;
                        state_write      <= W_WRITE;
                    end else if (aw_fire) begin
                        LSU_AXI4_AWREADY <= 1'b0;
                        state_write      <= W_WAIT_W;
                    end else if (w_fire) begin
                        LSU_AXI4_WREADY <= 1'b0;
                        state_write     <= W_WAIT_AW;
                    end
                end
                W_WAIT_W: begin
                    if (w_fire) begin
                        LSU_AXI4_WREADY <= 1'b0;
                        state_write     <= W_WRITE;
                    end
                end
                W_WAIT_AW: begin
                    if (aw_fire) begin
                        LSU_AXI4_AWREADY <= 1'b0;
                        state_write      <= W_WRITE;
                    end
                end
                default: begin
                    if (!LSU_AXI4_BVALID) begin
                        LSU_AXI4_BVALID <= 1'b1;
                    end else if (LSU_AXI4_BREADY) begin
                        LSU_AXI4_BVALID <= 1'b0;
                        state_write     <= W_IDLE;
                    end
                end
            endcase
        end
    end

    // Word index from address bits 11:2, upper bits wrap
    always_ff @(posedge CLK) begin
        if (ar_fire) begin
            read_idx <= LSU_AXI4_ARADDR[IDX_W+1:2];
        end
        if (aw_fire) begin
            write_idx <= LSU_AXI4_AWADDR[IDX_W+1:2];
        end
        if (w_fire) begin
            write_data <= LSU_AXI4_WDATA;
            write_strb <= LSU_AXI4_WSTRB;
        end
    end

    always_ff @(posedge CLK) begin
        if (state_read == R_DATA) begin
            LSU_AXI4_RDATA <= mem[read_idx];
        end
        if (mem_we) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (write_strb[i]) begin
                    mem[write_idx][8*i +: 8] <= write_data[8*i +: 8];
                end
            end
        end
    end

    a_bvalid_hold: assert property (@(posedge CLK) disable iff (rstn)
        LSU_AXI4_BVALID && !LSU_AXI4_BREADY |=> LSU_AXI4_BVALID);

endmodule

`default_nettype wire

// File: verilog/lsu_mem_top.sv
`default_nettype none
`include "lsu_defines.svh"

module lsu_mem_top (
    input  wire                         CLK,
    input  wire                         rstn,
    input  wire                         req,
    input  wire lsu_pkg::ls_kind_e      req_kind,
    input  wire lsu_pkg::ls_width_e     req_width,
    input  wire [`LSU_ADDR_WIDTH-1:0]   req_addr,
    input  wire [`LSU_DATA_WIDTH-1:0]   req_wdata,
    output logic                        busy,
    output logic                        done,
    output logic [`LSU_DATA_WIDTH-1:0]  load_data,
    output logic                        misaligned
);
    import lsu_pkg::*;

    // Decode to execute and result
    logic                           dec_valid;
    logic                           dec_misaligned;
    ls_kind_e                       dec_kind;
    ls_width_e                      dec_width;
    logic [`LSU_ADDR_WIDTH-1:0]     dec_word_addr;
    logic [`LSU_DATA_WIDTH/8-1:0]   dec_strb;
    logic [`LSU_DATA_WIDTH-1:0]     dec_wdata;
    logic [1:0]                     dec_offset;

    // Execute to result
    logic                           rsp_valid;
    ls_kind_e                       rsp_kind;
    logic [`LSU_DATA_WIDTH-1:0]     rsp_word;
    logic [1:0]                     rsp_offset;
    ls_width_e                      rsp_width;

    // AXI4-Lite between execute and the memory
    logic [`LSU_ADDR_WIDTH-1:0]     LSU_AXI4_ARADDR;
    logic                           LSU_AXI4_ARVALID;
    logic                           LSU_AXI4_ARREADY;
    logic [`LSU_DATA_WIDTH-1:0]     LSU_AXI4_RDATA;
    logic                           LSU_AXI4_RVALID;
    logic                           LSU_AXI4_RREADY;
    logic [`LSU_ADDR_WIDTH-1:0]     LSU_AXI4_AWADDR;
    logic                           LSU_AXI4_AWVALID;
    logic                           LSU_AXI4_AWREADY;
    logic [`LSU_DATA_WIDTH-1:0]     LSU_AXI4_WDATA;
    logic [`LSU_DATA_WIDTH/8-1:0]   LSU_AXI4_WSTRB;
    logic                           LSU_AXI4_WVALID;
    logic                           LSU_AXI4_WREADY;
    logic                           LSU_AXI4_BVALID;
    logic                           LSU_AXI4_BREADY;

    // Port and net names match one to one
    lsu_decode i_decode (.*);

    lsu_bus_execute i_execute (.*);

    lsu_load_result i_result (.*);

    sram_data i_sram (.*);

endmodule

`default_nettype wire

// File: tb/tb_lsu_mem_top.sv
`default_nettype none
`include "lsu_defines.svh"

module tb_lsu_mem_top;
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    localparam int AW           = `LSU_ADDR_WIDTH;
    localparam int DW           = `LSU_DATA_WIDTH;
    localparam int MEM_BYTES    = 4 * `LSU_MEM_WORDS;
    localparam int DONE_TIMEOUT = 100;

    logic            CLK;
    logic            rstn;
    logic            req;
    ls_kind_e        req_kind;
    ls_width_e       req_width;
    logic [AW-1:0]   req_addr;
    logic [DW-1:0]   req_wdata;
    logic            busy;
    logic            done;
    logic [DW-1:0]   load_data;
    logic            misaligned;

    // Byte-wide reference memory, little endian
    logic [7:0]      ref_mem [0:MEM_BYTES-1];
    logic [DW-1:0]   exp_data;
    logic            exp_mis;
    string           test_name;
    int              errors;
    int              checks;
    int              tests;
    int              errors_at_start;
    int              checks_at_start;
    integer          seed;

    lsu_mem_top i_dut (
        .CLK        (CLK),
        .rstn       (rstn),
        .req        (req),
        .req_kind   (req_kind),
        .req_width  (req_width),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .busy       (busy),
        .done       (done),
        .load_data  (load_data),
        .misaligned (misaligned)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    a_load_data: assert property (@(posedge CLK) disable iff (rstn)
        done |-> load_data == exp_data)
        else begin
            $display("mismatch %s load_data expected %h actual %h",
                     test_name, exp_data, $sampled(load_data));
            errors++;
        end

    a_misaligned: assert property (@(posedge CLK) disable iff (rstn)
        done |-> misaligned == exp_mis)
        else begin
            $display("mismatch %s misaligned expected %b actual %b",
                     test_name, exp_mis, $sampled(misaligned));
            errors++;
        end

    a_busy_rise: assert property (@(posedge CLK) disable iff (rstn)
        req && !busy |=> busy)
        else begin
            $display("busy did not rise after an accepted request in test %s", test_name);
            errors++;
        end

    a_busy_fall: assert property (@(posedge CLK) disable iff (rstn)
        $fell(busy) == done)
        else begin
            $display("busy did not fall together with done in test %s", test_name);
            errors++;
        end

    function automatic logic is_misaligned(input ls_width_e width, input logic [AW-1:0] addr);
        case (width)
            LS_H, LS_HU: return addr[0];
            LS_W:        return addr[1:0] != 2'b00;
            default:     return 1'b0;
        endcase
    endfunction

    function automatic logic [DW-1:0] model_load(input ls_width_e width,
                                                 input logic [AW-1:0] addr);
        logic [11:0] a;
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [7:0]  b2;
        logic [7:0]  b3;
        a  = addr[11:0];
        b0 = ref_mem[a];
        b1 = ref_mem[a + 12'd1];
        b2 = ref_mem[a + 12'd2];
        b3 = ref_mem[a + 12'd3];
        case (width)
            LS_B:    return {{24{b0[7]}}, b0};
            LS_BU:   return {24'h0, b0};
            LS_H:    return {{16{b1[7]}}, b1, b0};
            LS_HU:   return {16'h0, b1, b0};
            default: return {b3, b2, b1, b0};
        endcase
    endfunction

    task automatic model_store(input ls_width_e width, input logic [AW-1:0] addr,
                               input logic [DW-1:0] wdata);
        int          nbytes;
        logic [11:0] idx;
        nbytes = (width == LS_B) ? 1 : (width == LS_H) ? 2 : 4;
        for (int i = 0; i < nbytes; i++) begin
            idx          = addr[11:0] + 12'(i);
            ref_mem[idx] = wdata[8*i +: 8];
        end
    endtask

    // Optionally pulses a second store while the first request is busy
    task automatic issue_and_wait(input ls_kind_e kind, input ls_width_e width,
                                  input logic [AW-1:0] addr, input logic [DW-1:0] wdata,
                                  input bit inject);
        int   cycles;
        bit   seen;
        logic mis;
        @(negedge CLK);
        mis     = is_misaligned(width, addr);
        exp_mis = mis;
        if (mis || kind == LS_STORE) begin
            exp_data = '0;
        end else begin
            exp_data = model_load(width, addr);
        end
        if (kind == LS_STORE && !mis) begin
            model_store(width, addr, wdata);
        end
        req       = 1'b1;
        req_kind  = kind;
        req_width = width;
        req_addr  = addr;
        req_wdata = wdata;
        @(negedge CLK);
        req = 1'b0;
        if (inject) begin
            req       = 1'b1;
            req_kind  = LS_STORE;
            req_width = LS_W;
            req_wdata = ~wdata;
            @(negedge CLK);
            req = 1'b0;
        end
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            if (done) begin
                seen = 1'b1;
            end else begin
                @(negedge CLK);
                cycles++;
            end
        end
        if (seen) begin
            checks++;
        end else begin
            $display("timeout: done did not arrive within %0d cycles in test %s",
                     DONE_TIMEOUT, test_name);
            errors++;
        end
    endtask

    task automatic do_load(input ls_width_e width, input logic [AW-1:0] addr);
        issue_and_wait(LS_LOAD, width, addr, '0, 1'b0);
    endtask

    task automatic do_store(input ls_width_e width, input logic [AW-1:0] addr,
                            input logic [DW-1:0] wdata);
        issue_and_wait(LS_STORE, width, addr, wdata, 1'b0);
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        checks_at_start = checks;
    endtask

    task automatic finish_test();
        tests++;
        $display("test %s: %0d checks, %0d errors", test_name,
                 checks - checks_at_start, errors - errors_at_start);
    endtask

    function automatic ls_width_e width_from_code(input int code);
        case (code)
            0:       return LS_B;
            1:       return LS_H;
            2:       return LS_W;
            3:       return LS_BU;
            default: return LS_HU;
        endcase
    endfunction

    initial begin
        logic [31:0]   r;
        logic [AW-1:0] addr;
        ls_width_e     width;
        req       = 1'b0;
        req_kind  = LS_LOAD;
        req_width = LS_W;
        req_addr  = '0;
        req_wdata = '0;
        rstn      = 1'b1;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        seed      = 32'h1cfc1764;
        test_name = "reset";
        exp_data  = '0;
        exp_mis   = 1'b0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            ref_mem[i] = 8'h00;
        end
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        rstn = 1'b0;

        // Known contents for the test window before any load
        start_test("fill");
        for (int a = 0; a < 256; a += 4) begin
            addr = 32'(a);
            do_store(LS_W, addr, (addr * 32'h9e3779b1) ^ {addr[15:0], ~addr[15:0]});
        end
        finish_test();

        start_test("word_store_load");
        do_store(LS_W, 32'h40, 32'hdeadbeef);
        do_load(LS_W, 32'h40);
        do_load(LS_W, 32'h1040);
        do_load(LS_W, 32'hfff0_0040);
        finish_test();

        start_test("lane_merge");
        do_store(LS_W, 32'h48, 32'h11223344);
        do_store(LS_B, 32'h49, 32'h000000aa);
        do_store(LS_H, 32'h4a, 32'h0000bbcc);
        do_load(LS_W, 32'h48);
        do_store(LS_B, 32'h4f, 32'h12345677);
        do_load(LS_W, 32'h4c);
        finish_test();

        start_test("load_widths");
        do_store(LS_W, 32'h50, 32'h80ff7f01);
        do_store(LS_W, 32'h54, 32'h7fff8000);
        for (int a = 32'h50; a < 32'h58; a++) begin
            do_load(LS_B, 32'(a));
            do_load(LS_BU, 32'(a));
            if (a % 2 == 0) begin
                do_load(LS_H, 32'(a));
                do_load(LS_HU, 32'(a));
            end
        end
        do_load(LS_W, 32'h54);
        finish_test();

        start_test("misaligned");
        do_load(LS_H, 32'h51);
        do_load(LS_W, 32'h52);
        do_load(LS_HU, 32'h57);
        do_store(LS_H, 32'h53, 32'hcafe1234);
        do_store(LS_W, 32'h51, 32'h55aa55aa);
        do_load(LS_W, 32'h50);
        do_load(LS_W, 32'h54);
        finish_test();

        start_test("busy_ignore");
        issue_and_wait(LS_STORE, LS_W, 32'h58, 32'h0badf00d, 1'b1);
        do_load(LS_W, 32'h58);
        issue_and_wait(LS_LOAD, LS_W, 32'h5c, 32'h00000000, 1'b1);
        do_load(LS_W, 32'h5c);
        finish_test();

        start_test("random");
        for (int n = 0; n < 200; n++) begin
            r    = $random(seed);
            addr = 32'h80 + {26'b0, r[9:4]};
            if (r[0]) begin
                width = width_from_code(int'(r[3:1]) % 3);
            end else begin
                width = width_from_code(int'(r[3:1]) % 5);
            end
            if (width == LS_H || width == LS_HU) begin
                addr[0] = 1'b0;
            end else if (width == LS_W) begin
                addr[1:0] = 2'b00;
            end
            if (r[0]) begin
                do_store(width, addr, $random(seed));
            end else begin
                do_load(width, addr);
            end
        end
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+verilog
verilog/lsu_pkg.sv
verilog/lsu_decode.sv
verilog/lsu_bus_execute.sv
verilog/lsu_load_result.sv
verilog/sram_data.sv
verilog/lsu_mem_top.sv
tb/tb_lsu_mem_top.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_lsu_mem_top
FILELIST   = compile.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
